//--- files.f
rtl/dfr_cfg_pkg.sv
rtl/dfr_ctrl_pkg.sv
rtl/dfr_reg_decode.sv
rtl/dfr_reservoir.sv
rtl/dfr_readout.sv
rtl/dfr_execute.sv
rtl/dfr_result.sv
rtl/dfr_core_top.sv
sim/dfr_core_tb.sv

//--- rtl/dfr_cfg_pkg.sv
package dfr_cfg_pkg;

    localparam int NUM_VIRTUAL_NODES = 8;
    localparam int DATA_WIDTH        = 16;  // Signed samples and node states
    localparam int ACC_WIDTH         = 32;
    localparam int SAMPLE_ADDR_WIDTH = 6;   // 64 input samples
    localparam int NODE_SEL_WIDTH    = $clog2(NUM_VIRTUAL_NODES);

    // 1 passes the sample, 0 negates it
    localparam logic [NUM_VIRTUAL_NODES-1:0] INPUT_MASK = 8'b1011_0010;

    localparam int OUT_CREDITS   = 4;  // Also the output FIFO depth
    localparam int OUT_PTR_WIDTH = $clog2(OUT_CREDITS);
    localparam int OUT_CNT_WIDTH = $clog2(OUT_CREDITS + 1);

    localparam int REG_ADDR_WIDTH = 8;

    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        REG_CTRL        = 8'h00,
        REG_STATUS      = 8'h04,
        REG_NUM_SAMPLES = 8'h08,
        REG_WEIGHT_BASE = 8'h10,  // 8 weights up to 0x17
        REG_INPUT_BASE  = 8'h40   // 64 samples up to 0x7F
    } dfr_reg_e;

    localparam logic [REG_ADDR_WIDTH-1:0] WEIGHT_ADDR_MASK = 8'hf8;
    localparam logic [REG_ADDR_WIDTH-1:0] INPUT_ADDR_MASK  = 8'hc0;

endpackage

//--- rtl/dfr_core_top.sv
module dfr_core_top
    import dfr_cfg_pkg::*;
(
    input  logic                      s_axi_aclk_i,
    input  logic                      rst_n_i,
    input  logic                      reg_wen_i,
    input  logic                      reg_ren_i,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [31:0]               reg_wdata_i,
    output logic [31:0]               reg_rdata_o,
    output logic                      busy_o,
    output logic                      out_valid_o,
    output logic [ACC_WIDTH-1:0]      out_data_o,
    input  logic                      out_credit_i
);

    logic                                    start;
    logic                                    done;
    logic [SAMPLE_ADDR_WIDTH:0]              num_samples;
    logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] weights;
    logic                                    in_wen;
    logic [SAMPLE_ADDR_WIDTH-1:0]            in_waddr;
    logic [DATA_WIDTH-1:0]                   in_wdata;
    logic                                    res_push;
    logic                                    res_ready;
    logic [ACC_WIDTH-1:0]                    res_data;

    dfr_reg_decode dfr_reg_decode (
        .s_axi_aclk_i  (s_axi_aclk_i),
        .rst_n_i       (rst_n_i),
        .reg_wen_i     (reg_wen_i),
        .reg_ren_i     (reg_ren_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .busy_i        (busy_o),
        .done_i        (done),
        .reg_rdata_o   (reg_rdata_o),
        .start_o       (start),
        .num_samples_o (num_samples),
        .weights_o     (weights),
        .in_wen_o      (in_wen),
        .in_waddr_o    (in_waddr),
        .in_wdata_o    (in_wdata)
    );

    dfr_execute dfr_execute (
        .s_axi_aclk_i  (s_axi_aclk_i),
        .rst_n_i       (rst_n_i),
        .start_i       (start),
        .num_samples_i (num_samples),
        .weights_i     (weights),
        .in_wen_i      (in_wen),
        .in_waddr_i    (in_waddr),
        .in_wdata_i    (in_wdata),
        .res_ready_i   (res_ready),
        .busy_o        (busy_o),
        .done_o        (done),
        .res_push_o    (res_push),
        .res_data_o    (res_data)
    );

    dfr_result dfr_result (
        .s_axi_aclk_i (s_axi_aclk_i),
        .rst_n_i      (rst_n_i),
        .res_push_i   (res_push),
        .res_data_i   (res_data),
        .out_credit_i (out_credit_i),
        .res_ready_o  (res_ready),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o)
    );

endmodule

//--- rtl/dfr_ctrl_pkg.sv
package dfr_ctrl_pkg;

    // Per sample: FETCH once, STEP and READOUT once per node, then EMIT
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_STEP,
        ST_READOUT,
        ST_EMIT,    // Waits here on back-pressure
        ST_DONE
    } dfr_state_e;

endpackage

//--- rtl/dfr_execute.sv
module dfr_execute
    import dfr_cfg_pkg::*, dfr_ctrl_pkg::*;
(
    input  logic                                    s_axi_aclk_i,
    input  logic                                    rst_n_i,
    input  logic                                    start_i,
    input  logic [SAMPLE_ADDR_WIDTH:0]              num_samples_i,
    input  logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] weights_i,
    input  logic                                    in_wen_i,
    input  logic [SAMPLE_ADDR_WIDTH-1:0]            in_waddr_i,
    input  logic [DATA_WIDTH-1:0]                   in_wdata_i,
    input  logic                                    res_ready_i,
    output logic                                    busy_o,
    output logic                                    done_o,
    output logic                                    res_push_o,
    output logic [ACC_WIDTH-1:0]                    res_data_o
);

    logic [DATA_WIDTH-1:0]                   in_mem [2**SAMPLE_ADDR_WIDTH];
    logic [DATA_WIDTH-1:0]                   sample_q;
    logic [SAMPLE_ADDR_WIDTH:0]              sample_cnt_q;
    logic [NODE_SEL_WIDTH-1:0]               node_cnt_q;
    logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] nodes;
    dfr_state_e                              state_q;
    logic                                    run_start;
    logic                                    last_node;

    always_ff @(posedge s_axi_aclk_i) begin
        if (in_wen_i) begin
            in_mem[in_waddr_i] <= in_wdata_i;
        end
    end

    always_ff @(posedge s_axi_aclk_i) begin
        if (state_q == ST_FETCH) begin
            sample_q <= in_mem[sample_cnt_q[SAMPLE_ADDR_WIDTH-1:0]];
        end
    end

    assign run_start = start_i && !busy_o;
    assign last_node = node_cnt_q == NODE_SEL_WIDTH'(NUM_VIRTUAL_NODES - 1);

    always_ff @(posedge s_axi_aclk_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            sample_cnt_q <= '0;
            node_cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (run_start) begin
                        // Empty run finishes at once
                        state_q      <= (num_samples_i == '0) ? ST_DONE : ST_FETCH;
                        sample_cnt_q <= '0;
                    end
                end
                ST_FETCH: begin
                    state_q    <= ST_STEP;
                    node_cnt_q <= '0;
                end
                ST_STEP: begin
                    node_cnt_q <= last_node ? '0 : node_cnt_q + 1'b1;
                    if (last_node) state_q <= ST_READOUT;
                end
                ST_READOUT: begin
                    node_cnt_q <= last_node ? '0 : node_cnt_q + 1'b1;
                    if (last_node) state_q <= ST_EMIT;
                end
                ST_EMIT: begin
                    if (res_ready_i) begin
                        if (sample_cnt_q + 1'b1 == num_samples_i) begin
                            state_q <= ST_DONE;
                        end else begin
                            sample_cnt_q <= sample_cnt_q + 1'b1;
                            state_q      <= ST_FETCH;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o     = (state_q != ST_IDLE) && (state_q != ST_DONE);
    assign done_o     = state_q == ST_DONE;
    assign res_push_o = (state_q == ST_EMIT) && res_ready_i;

    dfr_reservoir dfr_reservoir (
        .s_axi_aclk_i (s_axi_aclk_i),
        .rst_n_i      (rst_n_i),
        .clear_i      (run_start),  // Fresh ring state per run
        .step_i       (state_q == ST_STEP),
        .node_sel_i   (node_cnt_q),
        .sample_i     (sample_q),
        .nodes_o      (nodes)
    );

    dfr_readout dfr_readout (
        .s_axi_aclk_i (s_axi_aclk_i),
        .rst_n_i      (rst_n_i),
        .clear_i      (state_q == ST_FETCH),
        .mac_i        (state_q == ST_READOUT),
        .node_sel_i   (node_cnt_q),
        .nodes_i      (nodes),
        .weights_i    (weights_i),
        .acc_o        (res_data_o)
    );

    // Never into a full FIFO or past the programmed sample count
    a_push_ready: assert property (@(posedge s_axi_aclk_i) disable iff (!rst_n_i)
        res_push_o |-> res_ready_i && (sample_cnt_q < num_samples_i));

endmodule

//--- rtl/dfr_readout.sv
module dfr_readout
    import dfr_cfg_pkg::*;
(
    input  logic                                    s_axi_aclk_i,
    input  logic                                    rst_n_i,
    input  logic                                    clear_i,
    input  logic                                    mac_i,
    input  logic [NODE_SEL_WIDTH-1:0]               node_sel_i,
    input  logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] nodes_i,
    input  logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] weights_i,
    output logic [ACC_WIDTH-1:0]                    acc_o
);

    logic signed [DATA_WIDTH-1:0]   node;
    logic signed [DATA_WIDTH-1:0]   weight;
    logic signed [2*DATA_WIDTH-1:0] product;
    logic [ACC_WIDTH-1:0]           acc_q;

    assign node    = nodes_i[node_sel_i*DATA_WIDTH +: DATA_WIDTH];
    assign weight  = weights_i[node_sel_i*DATA_WIDTH +: DATA_WIDTH];
    assign product = node * weight;

    // Accumulator wraps on overflow
    always_ff @(posedge s_axi_aclk_i) begin
        if (!rst_n_i || clear_i) begin
            acc_q <= '0;
        end else if (mac_i) begin
            acc_q <= acc_q + ACC_WIDTH'(product);
        end
    end

    assign acc_o = acc_q;

endmodule

//--- rtl/dfr_reg_decode.sv
module dfr_reg_decode
    import dfr_cfg_pkg::*;
(
    input  logic                                    s_axi_aclk_i,
    input  logic                                    rst_n_i,
    input  logic                                    reg_wen_i,
    input  logic                                    reg_ren_i,
    input  logic [REG_ADDR_WIDTH-1:0]               reg_addr_i,
    input  logic [31:0]                             reg_wdata_i,
    input  logic                                    busy_i,
    input  logic                                    done_i,
    output logic [31:0]                             reg_rdata_o,
    output logic                                    start_o,
    output logic [SAMPLE_ADDR_WIDTH:0]              num_samples_o,
    output logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] weights_o,
    output logic                                    in_wen_o,
    output logic [SAMPLE_ADDR_WIDTH-1:0]            in_waddr_o,
    output logic [DATA_WIDTH-1:0]                   in_wdata_o
);

    logic [DATA_WIDTH-1:0]        weight_q [NUM_VIRTUAL_NODES];
    logic [SAMPLE_ADDR_WIDTH:0]   num_samples_q;
    logic [31:0]                  rdata_q;
    logic                         is_weight;
    logic                         is_input;
    logic                         cfg_wen;
    logic [NODE_SEL_WIDTH-1:0]    weight_idx;

    assign is_weight  = (reg_addr_i & WEIGHT_ADDR_MASK) == REG_WEIGHT_BASE;
    assign is_input   = (reg_addr_i & INPUT_ADDR_MASK) == REG_INPUT_BASE;
    assign weight_idx = reg_addr_i[NODE_SEL_WIDTH-1:0];
    assign cfg_wen    = reg_wen_i && !busy_i;  // Config locked during a run

    assign start_o    = cfg_wen && (reg_addr_i == REG_CTRL) && reg_wdata_i[0];
    assign in_wen_o   = cfg_wen && is_input;
    assign in_waddr_o = reg_addr_i[SAMPLE_ADDR_WIDTH-1:0];
    assign in_wdata_o = reg_wdata_i[DATA_WIDTH-1:0];

    always_ff @(posedge s_axi_aclk_i) begin
        if (!rst_n_i) begin
            num_samples_q <= '0;
        end else if (cfg_wen && reg_addr_i == REG_NUM_SAMPLES) begin
            num_samples_q <= reg_wdata_i[SAMPLE_ADDR_WIDTH:0];
        end
    end

    always_ff @(posedge s_axi_aclk_i) begin
        if (cfg_wen && is_weight) begin
            weight_q[weight_idx] <= reg_wdata_i[DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge s_axi_aclk_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (reg_ren_i) begin
            if (is_weight) begin
                rdata_q <= 32'(weight_q[weight_idx]);
            end else begin
                case (reg_addr_i)
                    REG_STATUS:      rdata_q <= {30'b0, done_i, busy_i};
                    REG_NUM_SAMPLES: rdata_q <= 32'(num_samples_q);
                    default:         rdata_q <= '0;
                endcase
            end
        end
    end

    for (genvar i = 0; i < NUM_VIRTUAL_NODES; i++) begin : g_weights
        assign weights_o[i*DATA_WIDTH +: DATA_WIDTH] = weight_q[i];
    end

    assign num_samples_o = num_samples_q;
    assign reg_rdata_o   = rdata_q;

    // Start only from idle, and the core must react on the next cycle
    a_start_idle: assert property (@(posedge s_axi_aclk_i) disable iff (!rst_n_i)
        start_o |-> !busy_i ##1 (busy_i || done_i));

endmodule

//--- rtl/dfr_reservoir.sv
module dfr_reservoir
    import dfr_cfg_pkg::*;
(
    input  logic                                    s_axi_aclk_i,
    input  logic                                    rst_n_i,
    input  logic                                    clear_i,
    input  logic                                    step_i,
    input  logic [NODE_SEL_WIDTH-1:0]               node_sel_i,
    input  logic [DATA_WIDTH-1:0]                   sample_i,
    output logic [NUM_VIRTUAL_NODES*DATA_WIDTH-1:0] nodes_o
);

    logic [DATA_WIDTH-1:0] node_q [NUM_VIRTUAL_NODES];
    logic [DATA_WIDTH-1:0] node_prev;
    logic [DATA_WIDTH+1:0] sample_ext;
    logic [DATA_WIDTH+1:0] masked;
    logic [DATA_WIDTH+1:0] feedback;
    logic [DATA_WIDTH+1:0] sum;
    logic [DATA_WIDTH-1:0] sat;

    assign node_prev  = node_q[node_sel_i];
    assign sample_ext = {{2{sample_i[DATA_WIDTH-1]}}, sample_i};
    assign masked     = INPUT_MASK[node_sel_i] ? sample_ext : -sample_ext;
    // Half of the value from the previous ring turn
    assign feedback   = {{3{node_prev[DATA_WIDTH-1]}}, node_prev[DATA_WIDTH-1:1]};
    assign sum        = masked + feedback;

    always_comb begin
        if (sum[DATA_WIDTH+1:DATA_WIDTH-1] == '0 || sum[DATA_WIDTH+1:DATA_WIDTH-1] == '1) begin
            sat = sum[DATA_WIDTH-1:0];
        end else if (sum[DATA_WIDTH+1]) begin
            sat = {1'b1, {(DATA_WIDTH-1){1'b0}}};  // Most negative
        end else begin
            sat = {1'b0, {(DATA_WIDTH-1){1'b1}}};
        end
    end

    always_ff @(posedge s_axi_aclk_i) begin
        if (!rst_n_i || clear_i) begin
            for (int i = 0; i < NUM_VIRTUAL_NODES; i++) begin
                node_q[i] <= '0;
            end
        end else if (step_i) begin
            node_q[node_sel_i] <= sat;
        end
    end

    for (genvar i = 0; i < NUM_VIRTUAL_NODES; i++) begin : g_nodes
        assign nodes_o[i*DATA_WIDTH +: DATA_WIDTH] = node_q[i];
    end

endmodule

//--- rtl/dfr_result.sv
module dfr_result
    import dfr_cfg_pkg::*;
(
    input  logic                 s_axi_aclk_i,
    input  logic                 rst_n_i,
    input  logic                 res_push_i,
    input  logic [ACC_WIDTH-1:0] res_data_i,
    input  logic                 out_credit_i,
    output logic                 res_ready_o,
    output logic                 out_valid_o,
    output logic [ACC_WIDTH-1:0] out_data_o
);

    logic [ACC_WIDTH-1:0]     fifo_q [OUT_CREDITS];
    logic [OUT_PTR_WIDTH-1:0] wr_ptr_q;
    logic [OUT_PTR_WIDTH-1:0] rd_ptr_q;
    logic [OUT_CNT_WIDTH-1:0] count_q;
    logic [OUT_CNT_WIDTH-1:0] credit_q;
    logic [ACC_WIDTH-1:0]     out_data_q;
    logic                     out_valid_q;
    logic                     send;

    assign res_ready_o = count_q != OUT_CNT_WIDTH'(OUT_CREDITS);
    assign send        = (count_q != '0) && (credit_q != '0);

    always_ff @(posedge s_axi_aclk_i) begin
        if (res_push_i) begin
            fifo_q[wr_ptr_q] <= res_data_i;
        end
        if (send) begin
            out_data_q <= fifo_q[rd_ptr_q];
        end
    end

    always_ff @(posedge s_axi_aclk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            credit_q    <= OUT_CNT_WIDTH'(OUT_CREDITS);
            out_valid_q <= 1'b0;
        end else begin
            if (res_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (send) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({res_push_i, send})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            case ({out_credit_i, send})  // Return and spend cancel out
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
            out_valid_q <= send;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

    // Consumer must not return more credits than it was given
    a_credit_max: assert property (@(posedge s_axi_aclk_i) disable iff (!rst_n_i)
        credit_q <= OUT_CNT_WIDTH'(OUT_CREDITS));

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module dfr_core_tb -f files.f -o dfr_core_sim
./obj_dir/dfr_core_sim | tee sim.log
if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- sim/dfr_core_tb.sv
module dfr_core_tb
    import dfr_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 2000;  // Cycles per wait loop
    localparam logic [DATA_WIDTH-1:0] SAT_VALUES [8] = '{
        16'h7fff, 16'h8000, 16'h7530, 16'h7fff, 16'h8000, 16'h8000, 16'h61a8, 16'h7fff
    };

    logic                      clk;
    logic                      rst_n;
    logic                      reg_wen;
    logic                      reg_ren;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [31:0]               reg_wdata;
    logic [31:0]               reg_rdata;
    logic                      busy;
    logic                      out_valid;
    logic [ACC_WIDTH-1:0]      out_data;
    logic                      out_credit = 1'b0;

    logic [DATA_WIDTH-1:0] weight_m [NUM_VIRTUAL_NODES];
    logic [DATA_WIDTH-1:0] sample_m [2**SAMPLE_ADDR_WIDTH];
    logic [ACC_WIDTH-1:0]  exp_q [$];
    logic [ACC_WIDTH-1:0]  got_q [$];
    logic [31:0]           lfsr_q = 32'h3150_6950;
    logic                  credit_en = 1'b1;
    logic                  timeout_hit = 1'b0;
    int                    credits_back = 0;
    int                    sat_hits;
    int                    checks = 0;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    dfr_core_top dut0 (
        .s_axi_aclk_i (clk),
        .rst_n_i      (rst_n),
        .reg_wen_i    (reg_wen),
        .reg_ren_i    (reg_ren),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .busy_o       (busy),
        .out_valid_o  (out_valid),
        .out_data_o   (out_data),
        .out_credit_i (out_credit)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Output consumer
    always @(negedge clk) begin
        if (rst_n && out_valid) got_q.push_back(out_data);
    end

    // One credit back per received word while enabled
    always @(posedge clk) begin
        if (credit_en && credits_back < got_q.size()) begin
            out_credit <= 1'b1;
            credits_back++;
        end else begin
            out_credit <= 1'b0;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [DATA_WIDTH-1:0] w;
        w = '0;
        for (int b = 0; b < DATA_WIDTH; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[DATA_WIDTH-2:0], lfsr_q[31]};
        end
        return w;
    endfunction

    // Reference: masked input plus half feedback, saturated, then dot product
    function automatic void build_expected(input int count);
        int          node [NUM_VIRTUAL_NODES];
        int          masked;
        int          sum;
        logic [31:0] acc;
        exp_q.delete();
        for (int n = 0; n < NUM_VIRTUAL_NODES; n++) node[n] = 0;
        for (int s = 0; s < count; s++) begin
            for (int n = 0; n < NUM_VIRTUAL_NODES; n++) begin
                masked = int'($signed(sample_m[s]));
                if (!INPUT_MASK[n]) masked = -masked;
                sum = masked + (node[n] >>> 1);
                if (sum > 32767 || sum < -32768) sat_hits++;
                if (sum > 32767) sum = 32767;
                if (sum < -32768) sum = -32768;
                node[n] = sum;
            end
            acc = '0;
            for (int n = 0; n < NUM_VIRTUAL_NODES; n++) begin
                acc = acc + 32'(node[n] * int'($signed(weight_m[n])));
            end
            exp_q.push_back(acc);
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s within %0d cycles", what, WAIT_LIMIT);
        timeout_hit = 1'b1;
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("%s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wen   <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wen   <= 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        reg_ren  <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_ren  <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic load_samples(input int count);
        for (int i = 0; i < count; i++) begin
            reg_write(REG_INPUT_BASE + 8'(i), 32'(sample_m[i]));
        end
        reg_write(REG_NUM_SAMPLES, 32'(count));
    endtask

    task automatic wait_idle(output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            ok = !busy;
            cycles++;
        end
        if (!ok) report_timeout("core did not go idle");
    endtask

    task automatic wait_words(input int target, output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            ok = got_q.size() >= target;
            cycles++;
        end
        if (!ok) report_timeout("output words did not arrive");
    endtask

    task automatic compare_outputs(input int base, input int count);
        logic ok;
        wait_idle(ok);
        if (ok) wait_words(base + count, ok);
        if (ok) begin
            for (int i = 0; i < count; i++) begin
                check_value($sformatf("output %0d", i), got_q[base + i], exp_q[i]);
            end
        end
    endtask

    task automatic test_reset_state();
        int          err0;
        int          seen;
        logic [31:0] data;
        err0 = errors;
        reg_read(REG_STATUS, data);
        check_value("status after reset", data, 32'h0);
        seen = 0;
        repeat (20) begin
            @(negedge clk);
            if (out_valid !== 1'b0) seen++;
        end
        check_value("valid pulses after reset", 32'(seen), 32'h0);
        finish_test("reset_state", err0);
    endtask

    task automatic test_register_access();
        int          err0;
        int          base;
        logic [31:0] data;
        err0 = errors;
        for (int i = 0; i < NUM_VIRTUAL_NODES; i++) begin
            weight_m[i] = random_word();
            reg_write(REG_WEIGHT_BASE + 8'(i), 32'(weight_m[i]));
        end
        reg_write(REG_NUM_SAMPLES, 32'd4);
        for (int i = 0; i < NUM_VIRTUAL_NODES; i++) begin
            reg_read(REG_WEIGHT_BASE + 8'(i), data);
            check_value($sformatf("weight %0d readback", i), data, 32'(weight_m[i]));
        end
        reg_read(REG_NUM_SAMPLES, data);
        check_value("sample count readback", data, 32'd4);
        for (int i = 0; i < 4; i++) sample_m[i] = random_word();
        load_samples(4);
        build_expected(4);
        base = got_q.size();
        reg_write(REG_CTRL, 32'h1);
        // All of these land while the run is busy
        reg_write(REG_WEIGHT_BASE, 32'(~weight_m[0]));
        reg_write(REG_NUM_SAMPLES, 32'd9);
        reg_write(REG_INPUT_BASE + 8'd3, 32'(~sample_m[3]));
        reg_read(REG_STATUS, data);
        check_value("status while busy", data, 32'h1);
        reg_read(REG_WEIGHT_BASE, data);
        check_value("weight 0 locked", data, 32'(weight_m[0]));
        reg_read(REG_NUM_SAMPLES, data);
        check_value("sample count locked", data, 32'd4);
        compare_outputs(base, 4);
        finish_test("register_access", err0);
    endtask

    task automatic test_random_run();
        int err0;
        int base;
        err0 = errors;
        for (int i = 0; i < 16; i++) sample_m[i] = random_word();
        load_samples(16);
        build_expected(16);
        base = got_q.size();
        reg_write(REG_CTRL, 32'h1);
        compare_outputs(base, 16);
        finish_test("random_run", err0);
    endtask

    task automatic test_backpressure();
        int   err0;
        int   base;
        int   cycles;
        logic ok;
        err0 = errors;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin  // All credits home first
            @(negedge clk);
            ok = credits_back == got_q.size();
            cycles++;
        end
        if (!ok) report_timeout("credits were not returned");
        credit_en = 1'b0;
        for (int i = 0; i < 10; i++) sample_m[i] = random_word();
        load_samples(10);
        build_expected(10);
        base = got_q.size();
        reg_write(REG_CTRL, 32'h1);
        wait_words(base + OUT_CREDITS, ok);
        repeat (200) @(negedge clk);
        check_value("words sent without credit", 32'(got_q.size() - base), 32'(OUT_CREDITS));
        check_value("busy while stalled", 32'(busy), 32'h1);
        @(negedge clk);
        credit_en = 1'b1;
        compare_outputs(base, 10);
        finish_test("backpressure", err0);
    endtask

    task automatic test_saturation();
        int err0;
        int base;
        err0 = errors;
        for (int i = 0; i < 8; i++) sample_m[i] = SAT_VALUES[i];
        load_samples(8);
        sat_hits = 0;
        build_expected(8);
        check_value("model saturated", 32'(sat_hits > 0), 32'h1);
        base = got_q.size();
        reg_write(REG_CTRL, 32'h1);
        compare_outputs(base, 8);
        finish_test("saturation", err0);
    endtask

    task automatic test_restart();
        int          err0;
        int          first;
        int          second;
        logic [31:0] data;
        err0 = errors;
        first = got_q.size();
        reg_write(REG_CTRL, 32'h1);  // Saturation samples still loaded
        compare_outputs(first, 8);
        second = got_q.size();
        reg_write(REG_CTRL, 32'h1);
        compare_outputs(second, 8);
        check_value("busy after run", 32'(busy), 32'h0);
        reg_read(REG_STATUS, data);
        check_value("status after run", data, 32'h2);
        finish_test("restart", err0);
    endtask

    initial begin
        rst_n     = 1'b0;
        reg_wen   = 1'b0;
        reg_ren   = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        if (!timeout_hit) test_register_access();
        if (!timeout_hit) test_random_run();
        if (!timeout_hit) test_backpressure();
        if (!timeout_hit) test_saturation();
        if (!timeout_hit) test_restart();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
